/* include/cpu_params.svh */
// ==========================================================================
// Width settings for the pipelined CPU. Pulled in by the type package and
// by the top level, which sizes both memories from these values.
// ==========================================================================
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and address word
`define CPU_DATA_W 32

// register index, 32 registers
`define CPU_REG_ADDR_W 5

// instruction memory word address, 512 words
`define CPU_IMEM_ADDR_W 9

// data memory word address, 1024 words
`define CPU_DMEM_ADDR_W 10

`endif

/* logic/cpu_pkg.sv */
// ==========================================================================
// Types shared by the CPU stages: words, register indices, instruction
// fields and ALU operations. Modules import it in their headers.
// ==========================================================================
`default_nettype none
`include "cpu_params.svh"

package cpu_pkg;

   typedef logic [`CPU_DATA_W-1:0] word_t;
   typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

   typedef enum logic [5:0] {
      op_rtype = 6'd0,
      op_j     = 6'd2,
      op_beq   = 6'd4,
      op_addi  = 6'd8,
      op_lw    = 6'd35,
      op_sw    = 6'd43
   } opcode_e;

   // funct field of the R-type instructions
   typedef enum logic [5:0] {
      fn_add = 6'd32,
      fn_sub = 6'd34,
      fn_and = 6'd36,
      fn_or  = 6'd37,
      fn_slt = 6'd42
   } funct_e;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_slt
   } alu_op_e;

endpackage

`default_nettype wire

/* logic/dual_port_sram.sv */
// ==========================================================================
// Word memory shared by instruction and data storage. The pipeline port
// reads combinationally; the test port has a registered read.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module dual_port_sram
   import cpu_pkg::*;
#(
   parameter int ADDR_W = 9
) (
   input  wire        clk,
   input  wire word_t addr,
   input  wire        wen,
   input  wire        ren,
   input  wire word_t wdata,
   input  wire word_t addr_ext,
   input  wire        wen_ext,
   input  wire        ren_ext,
   input  wire word_t wdata_ext,
   output word_t      rdata,
   output word_t      rdata_ext
);

   word_t mem [2**ADDR_W];
   logic [ADDR_W-1:0] idx;
   logic [ADDR_W-1:0] idx_ext;

   // both addresses are word indices, upper bits ignored
   assign idx = addr[ADDR_W-1:0];
   assign idx_ext = addr_ext[ADDR_W-1:0];

   assign rdata = ren ? mem[idx] : '0;

   // test port is last, so it wins a same-word collision
   always_ff @(posedge clk) begin
      if (wen) begin
         mem[idx] <= wdata;
      end
      if (wen_ext) begin
         mem[idx_ext] <= wdata_ext;
      end
      if (ren_ext) begin
         rdata_ext <= mem[idx_ext];
      end
   end

endmodule

`default_nettype wire

/* logic/fetch_stage.sv */
// ==========================================================================
// Fetch stage: program counter and the IF/ID register. Decode steers it
// with stall and redirect; enable low freezes everything here.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
   import cpu_pkg::*;
(
   input  wire        clk,
   input  wire        arst_n,
   input  wire        enable,
   input  wire        stall,
   input  wire        redirect,
   input  wire word_t redirect_pc,
   input  wire word_t imem_rdata,
   output word_t      imem_addr,
   output word_t      if_instr,
   output word_t      if_pc_plus4
);

   word_t pc;
   word_t pc_plus4;

   assign pc_plus4 = pc + word_t'(4);

   // byte address to word index
   assign imem_addr = pc >> 2;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc <= '0;
      end else if (enable) begin
         if (redirect) begin
            pc <= redirect_pc;
         end else if (!stall) begin
            pc <= pc_plus4;
         end
      end
   end

   // the slot fetched behind a taken branch or jump becomes a nop
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         if_instr <= '0;
      end else if (enable) begin
         if (redirect) begin
            if_instr <= '0;
         end else if (!stall) begin
            if_instr <= imem_rdata;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (enable && !stall) begin
         if_pc_plus4 <= pc_plus4;
      end
   end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// ==========================================================================
// Decode stage: control decode, register file, beq and j resolution, the
// hazard stall and the ID/EX register feeding execute.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module decode_stage
   import cpu_pkg::*;
(
   input  wire            clk,
   input  wire            arst_n,
   input  wire            enable,
   input  wire word_t     if_instr,
   input  wire word_t     if_pc_plus4,
   input  wire reg_addr_t mem_dest,
   input  wire            mem_reg_write,
   input  wire reg_addr_t wb_dest,
   input  wire            wb_reg_write,
   input  wire word_t     wb_data,
   output logic           stall,
   output logic           redirect,
   output word_t          redirect_pc,
   output word_t          ex_rs_val,
   output word_t          ex_rt_val,
   output word_t          ex_imm,
   output reg_addr_t      ex_rs,
   output reg_addr_t      ex_rt,
   output reg_addr_t      ex_dest,
   output alu_op_e        ex_alu_op,
   output logic           ex_alu_src,
   output logic           ex_mem_read,
   output logic           ex_mem_write,
   output logic           ex_reg_write
);

   word_t regs [2**$bits(reg_addr_t)];
   opcode_e opcode;
   funct_e funct;
   reg_addr_t rs, rt, rd, dest, rt_src;
   word_t rs_val, rt_val, imm_ext, branch_pc, jump_pc;
   alu_op_e dec_alu_op;
   logic dec_reg_write, dec_mem_read, dec_mem_write, dec_alu_src;
   logic dest_is_rt, uses_rt, is_beq, is_j;
   logic load_use, branch_wait;

   // producer d collides with a source, r0 never counts
   function automatic logic hits(reg_addr_t d, reg_addr_t a, reg_addr_t b);
      return (d != '0) && ((d == a) || (d == b));
   endfunction

   assign opcode = opcode_e'(if_instr[31:26]);
   assign funct = funct_e'(if_instr[5:0]);
   assign rs = if_instr[25:21];
   assign rt = if_instr[20:16];
   assign rd = if_instr[15:11];
   assign imm_ext = word_t'($signed(if_instr[15:0]));

   always_comb begin
      dec_alu_op = alu_add;
      dec_reg_write = 1'b0;
      dec_mem_read = 1'b0;
      dec_mem_write = 1'b0;
      dec_alu_src = 1'b0;
      dest_is_rt = 1'b0;
      uses_rt = 1'b0;
      is_beq = 1'b0;
      is_j = 1'b0;
      case (opcode)
         op_rtype: begin
            uses_rt = 1'b1;
            dec_reg_write = 1'b1;
            case (funct)
               fn_add: dec_alu_op = alu_add;
               fn_sub: dec_alu_op = alu_sub;
               fn_and: dec_alu_op = alu_and;
               fn_or: dec_alu_op = alu_or;
               fn_slt: dec_alu_op = alu_slt;
               default: dec_reg_write = 1'b0;
            endcase
         end
         op_addi: begin
            dec_reg_write = 1'b1;
            dec_alu_src = 1'b1;
            dest_is_rt = 1'b1;
         end
         op_lw: begin
            dec_reg_write = 1'b1;
            dec_mem_read = 1'b1;
            dec_alu_src = 1'b1;
            dest_is_rt = 1'b1;
         end
         op_sw: begin
            dec_mem_write = 1'b1;
            dec_alu_src = 1'b1;
            uses_rt = 1'b1;
         end
         op_beq: begin
            is_beq = 1'b1;
            uses_rt = 1'b1;
         end
         op_j: is_j = 1'b1;
         // anything else passes through as a nop
         default: ;
      endcase
   end

   assign dest = dest_is_rt ? rt : rd;

   // writeback lands this cycle, so a same-cycle read sees it
   assign rs_val = (rs == '0) ? '0 :
                   (wb_reg_write && wb_dest == rs) ? wb_data : regs[rs];
   assign rt_val = (rt == '0) ? '0 :
                   (wb_reg_write && wb_dest == rt) ? wb_data : regs[rt];

   always_ff @(posedge clk) begin
      if (enable && wb_reg_write) begin
         regs[wb_dest] <= wb_data;
      end
   end

   assign rt_src = uses_rt ? rt : '0;
   assign load_use = ex_mem_read && hits(ex_dest, rs, rt_src);

   // beq compares raw register values, so wait for producers in EX and MEM
   assign branch_wait = is_beq && ((ex_reg_write && hits(ex_dest, rs, rt)) ||
                                   (mem_reg_write && hits(mem_dest, rs, rt)));
   assign stall = load_use || branch_wait;

   assign branch_pc = if_pc_plus4 + (imm_ext << 2);
   assign jump_pc = {if_pc_plus4[31:28], if_instr[25:0], 2'b00};
   assign redirect = !stall && (is_j || (is_beq && rs_val == rt_val));
   assign redirect_pc = is_j ? jump_pc : branch_pc;

   // a stall sends a bubble into execute
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem_read <= 1'b0;
         ex_mem_write <= 1'b0;
         ex_reg_write <= 1'b0;
      end else if (enable) begin
         ex_mem_read <= dec_mem_read && !stall;
         ex_mem_write <= dec_mem_write && !stall;
         ex_reg_write <= dec_reg_write && !stall;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         ex_rs_val <= rs_val;
         ex_rt_val <= rt_val;
         ex_imm <= imm_ext;
         ex_rs <= rs;
         ex_rt <= rt;
         ex_dest <= dest;
         ex_alu_op <= dec_alu_op;
         ex_alu_src <= dec_alu_src;
      end
   end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
// ==========================================================================
// Execute stage: operand forwarding from EX/MEM and MEM/WB, the ALU and
// the EX/MEM register.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module execute_stage
   import cpu_pkg::*;
(
   input  wire            clk,
   input  wire            arst_n,
   input  wire            enable,
   input  wire word_t     ex_rs_val,
   input  wire word_t     ex_rt_val,
   input  wire word_t     ex_imm,
   input  wire reg_addr_t ex_rs,
   input  wire reg_addr_t ex_rt,
   input  wire reg_addr_t ex_dest,
   input  wire alu_op_e   ex_alu_op,
   input  wire            ex_alu_src,
   input  wire            ex_mem_read,
   input  wire            ex_mem_write,
   input  wire            ex_reg_write,
   input  wire reg_addr_t wb_dest,
   input  wire            wb_reg_write,
   input  wire word_t     wb_data,
   output word_t          mem_alu_result,
   output word_t          mem_store_val,
   output reg_addr_t      mem_dest,
   output logic           mem_mem_read,
   output logic           mem_mem_write,
   output logic           mem_reg_write
);

   word_t op_a, op_b, fwd_b, alu_result;

   // the nearer producer wins; a load in MEM never meets a consumer here
   function automatic word_t pick(reg_addr_t src, word_t reg_val);
      if (mem_reg_write && mem_dest != '0 && mem_dest == src) begin
         return mem_alu_result;
      end
      if (wb_reg_write && wb_dest != '0 && wb_dest == src) begin
         return wb_data;
      end
      return reg_val;
   endfunction

   always_comb begin
      op_a = pick(ex_rs, ex_rs_val);
      fwd_b = pick(ex_rt, ex_rt_val);
      op_b = ex_alu_src ? ex_imm : fwd_b;
   end

   always_comb begin
      case (ex_alu_op)
         alu_sub: alu_result = op_a - op_b;
         alu_and: alu_result = op_a & op_b;
         alu_or: alu_result = op_a | op_b;
         alu_slt: alu_result = word_t'($signed(op_a) < $signed(op_b));
         default: alu_result = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_mem_read <= 1'b0;
         mem_mem_write <= 1'b0;
         mem_reg_write <= 1'b0;
      end else if (enable) begin
         mem_mem_read <= ex_mem_read;
         mem_mem_write <= ex_mem_write;
         mem_reg_write <= ex_reg_write;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         mem_alu_result <= alu_result;
         mem_store_val <= fwd_b;
         mem_dest <= ex_dest;
      end
   end

endmodule

`default_nettype wire

/* logic/memory_stage.sv */
// ==========================================================================
// Memory stage: data memory access, the MEM/WB register and the value
// written back to the register file.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module memory_stage
   import cpu_pkg::*;
(
   input  wire            clk,
   input  wire            arst_n,
   input  wire            enable,
   input  wire word_t     mem_alu_result,
   input  wire word_t     mem_store_val,
   input  wire reg_addr_t mem_dest,
   input  wire            mem_mem_read,
   input  wire            mem_mem_write,
   input  wire            mem_reg_write,
   input  wire word_t     dmem_rdata,
   output word_t          dmem_addr,
   output logic           dmem_wen,
   output word_t          dmem_wdata,
   output reg_addr_t      wb_dest,
   output logic           wb_reg_write,
   output word_t          wb_data
);

   logic wb_is_load;
   word_t wb_load_data;
   word_t wb_alu_result;

   assign dmem_addr = mem_alu_result >> 2;
   // a frozen pipeline must not repeat a store
   assign dmem_wen = mem_mem_write && enable;
   assign dmem_wdata = mem_store_val;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_reg_write <= 1'b0;
         wb_is_load <= 1'b0;
      end else if (enable) begin
         wb_reg_write <= mem_reg_write;
         wb_is_load <= mem_mem_read;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         wb_dest <= mem_dest;
         wb_load_data <= dmem_rdata;
         wb_alu_result <= mem_alu_result;
      end
   end

   assign wb_data = wb_is_load ? wb_load_data : wb_alu_result;

endmodule

`default_nettype wire

/* logic/cpu.sv */
// ==========================================================================
// Top of the five-stage CPU. Enable runs or freezes the pipeline; the two
// test ports load programs and read results while it is frozen.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu
   import cpu_pkg::*;
(
   input  wire        clk,
   input  wire        arst_n,
   input  wire        enable,
   input  wire word_t addr_ext,
   input  wire        wen_ext,
   input  wire        ren_ext,
   input  wire word_t wdata_ext,
   input  wire word_t addr_ext_2,
   input  wire        wen_ext_2,
   input  wire        ren_ext_2,
   input  wire word_t wdata_ext_2,
   output word_t      rdata_ext,
   output word_t      rdata_ext_2
);

   word_t imem_addr, imem_rdata, if_instr, if_pc_plus4, redirect_pc;
   logic stall, redirect;
   word_t ex_rs_val, ex_rt_val, ex_imm;
   reg_addr_t ex_rs, ex_rt, ex_dest;
   alu_op_e ex_alu_op;
   logic ex_alu_src, ex_mem_read, ex_mem_write, ex_reg_write;
   word_t mem_alu_result, mem_store_val;
   reg_addr_t mem_dest;
   logic mem_mem_read, mem_mem_write, mem_reg_write;
   word_t dmem_addr, dmem_wdata, dmem_rdata;
   logic dmem_wen;
   reg_addr_t wb_dest;
   logic wb_reg_write;
   word_t wb_data;

   fetch_stage fetch0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .stall      (stall),
      .redirect   (redirect),
      .redirect_pc(redirect_pc),
      .imem_rdata (imem_rdata),
      .imem_addr  (imem_addr),
      .if_instr   (if_instr),
      .if_pc_plus4(if_pc_plus4)
   );

   // instruction memory, written only through the test port
   dual_port_sram #(
      .ADDR_W(`CPU_IMEM_ADDR_W)
   ) imem (
      .clk      (clk),
      .addr     (imem_addr),
      .wen      (1'b0),
      .ren      (1'b1),
      .wdata    ('0),
      .addr_ext (addr_ext),
      .wen_ext  (wen_ext),
      .ren_ext  (ren_ext),
      .wdata_ext(wdata_ext),
      .rdata    (imem_rdata),
      .rdata_ext(rdata_ext)
   );

   decode_stage decode0 (
      .clk          (clk),
      .arst_n       (arst_n),
      .enable       (enable),
      .if_instr     (if_instr),
      .if_pc_plus4  (if_pc_plus4),
      .mem_dest     (mem_dest),
      .mem_reg_write(mem_reg_write),
      .wb_dest      (wb_dest),
      .wb_reg_write (wb_reg_write),
      .wb_data      (wb_data),
      .stall        (stall),
      .redirect     (redirect),
      .redirect_pc  (redirect_pc),
      .ex_rs_val    (ex_rs_val),
      .ex_rt_val    (ex_rt_val),
      .ex_imm       (ex_imm),
      .ex_rs        (ex_rs),
      .ex_rt        (ex_rt),
      .ex_dest      (ex_dest),
      .ex_alu_op    (ex_alu_op),
      .ex_alu_src   (ex_alu_src),
      .ex_mem_read  (ex_mem_read),
      .ex_mem_write (ex_mem_write),
      .ex_reg_write (ex_reg_write)
   );

   execute_stage execute0 (
      .clk           (clk),
      .arst_n        (arst_n),
      .enable        (enable),
      .ex_rs_val     (ex_rs_val),
      .ex_rt_val     (ex_rt_val),
      .ex_imm        (ex_imm),
      .ex_rs         (ex_rs),
      .ex_rt         (ex_rt),
      .ex_dest       (ex_dest),
      .ex_alu_op     (ex_alu_op),
      .ex_alu_src    (ex_alu_src),
      .ex_mem_read   (ex_mem_read),
      .ex_mem_write  (ex_mem_write),
      .ex_reg_write  (ex_reg_write),
      .wb_dest       (wb_dest),
      .wb_reg_write  (wb_reg_write),
      .wb_data       (wb_data),
      .mem_alu_result(mem_alu_result),
      .mem_store_val (mem_store_val),
      .mem_dest      (mem_dest),
      .mem_mem_read  (mem_mem_read),
      .mem_mem_write (mem_mem_write),
      .mem_reg_write (mem_reg_write)
   );

   memory_stage memory0 (
      .clk           (clk),
      .arst_n        (arst_n),
      .enable        (enable),
      .mem_alu_result(mem_alu_result),
      .mem_store_val (mem_store_val),
      .mem_dest      (mem_dest),
      .mem_mem_read  (mem_mem_read),
      .mem_mem_write (mem_mem_write),
      .mem_reg_write (mem_reg_write),
      .dmem_rdata    (dmem_rdata),
      .dmem_addr     (dmem_addr),
      .dmem_wen      (dmem_wen),
      .dmem_wdata    (dmem_wdata),
      .wb_dest       (wb_dest),
      .wb_reg_write  (wb_reg_write),
      .wb_data       (wb_data)
   );

   dual_port_sram #(
      .ADDR_W(`CPU_DMEM_ADDR_W)
   ) dmem (
      .clk      (clk),
      .addr     (dmem_addr),
      .wen      (dmem_wen),
      .ren      (1'b1),
      .wdata    (dmem_wdata),
      .addr_ext (addr_ext_2),
      .wen_ext  (wen_ext_2),
      .ren_ext  (ren_ext_2),
      .wdata_ext(wdata_ext_2),
      .rdata    (dmem_rdata),
      .rdata_ext(rdata_ext_2)
   );

endmodule

`default_nettype wire

/* sim/cpu_tb_model.sv */
// ==========================================================================
// Testbench model for the CPU: LFSR step, instruction encoders and an
// instruction-level interpreter that gives the expected data memory.
// ==========================================================================
`default_nettype none

package cpu_tb_model;

   localparam int PROG_WORDS = 128;
   localparam int DATA_WORDS = 64;

   localparam logic [5:0] OP_RTYPE = 6'd0;
   localparam logic [5:0] OP_J = 6'd2;
   localparam logic [5:0] OP_BEQ = 6'd4;
   localparam logic [5:0] OP_ADDI = 6'd8;
   localparam logic [5:0] OP_LW = 6'd35;
   localparam logic [5:0] OP_SW = 6'd43;
   localparam logic [5:0] FN_ADD = 6'd32;
   localparam logic [5:0] FN_SUB = 6'd34;
   localparam logic [5:0] FN_AND = 6'd36;
   localparam logic [5:0] FN_OR = 6'd37;
   localparam logic [5:0] FN_SLT = 6'd42;

   typedef logic [31:0] prog_t [PROG_WORDS];
   typedef logic [31:0] data_t [DATA_WORDS];

   // 16-bit Galois LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rd,
                                              input logic [4:0] rs, input logic [4:0] rt);
      return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                              input logic [4:0] rs, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // word index of the target, as the instruction field holds it
   function automatic logic [31:0] jump_word(input logic [25:0] idx);
      return {OP_J, idx};
   endfunction

   // architectural run from pc 0 until the jump to itself
   function automatic void run_reference(input prog_t prog, output data_t dmem);
      logic [31:0] regs [32];
      logic [31:0] pc, instr, a, b, imm, addr, res, target;
      logic [5:0] op, fn;
      logic [4:0] rs, rt, rd;
      logic done;
      int steps;
      foreach (regs[i]) regs[i] = '0;
      foreach (dmem[i]) dmem[i] = '0;
      pc = '0;
      done = 1'b0;
      steps = 0;
      while (!done && steps < 4000) begin
         instr = prog[pc[8:2]];
         op = instr[31:26];
         rs = instr[25:21];
         rt = instr[20:16];
         rd = instr[15:11];
         fn = instr[5:0];
         a = regs[rs];
         b = regs[rt];
         imm = {{16{instr[15]}}, instr[15:0]};
         addr = a + imm;
         res = '0;
         pc = pc + 32'd4;
         case (op)
            OP_RTYPE: begin
               case (fn)
                  FN_ADD: res = a + b;
                  FN_SUB: res = a - b;
                  FN_AND: res = a & b;
                  FN_OR: res = a | b;
                  FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: rd = 5'd0;
               endcase
               if (rd != 5'd0) regs[rd] = res;
            end
            OP_ADDI: if (rt != 5'd0) regs[rt] = addr;
            OP_LW: if (rt != 5'd0) regs[rt] = dmem[addr[7:2]];
            OP_SW: dmem[addr[7:2]] = b;
            OP_BEQ: if (a == b) pc = pc + (imm << 2);
            OP_J: begin
               target = {pc[31:28], instr[25:0], 2'b00};
               done = (target == pc - 32'd4);
               pc = target;
            end
            default: ;
         endcase
         steps++;
      end
   endfunction

endpackage

`default_nettype wire

/* sim/cpu_tb.sv */
// ==========================================================================
// Testbench for the pipelined CPU. Loads each program through the test
// ports, runs it, reads the result words back and checks them against the
// interpreter in cpu_tb_model.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
   import cpu_tb_model::*;
();

   localparam int PERIOD_NS = 100;
   localparam int CHECK_WORDS = 32;
   localparam int MAX_BUDGET = 2 * PROG_WORDS + 30;
   // freeze while the dependent forwarding chain fills the pipeline
   localparam int FREEZE_AFTER = 20;
   // reset, program load, clearing, readback and the freeze window
   localparam int SETUP_CYCLES = 8 + 2 * PROG_WORDS + 4 * CHECK_WORDS + 20;
   localparam int WATCHDOG_NS = (6 * (MAX_BUDGET + SETUP_CYCLES) + 50) * PERIOD_NS;

   logic clk, arst_n, enable;
   logic [31:0] addr_ext, wdata_ext, addr_ext_2, wdata_ext_2;
   logic wen_ext, ren_ext, wen_ext_2, ren_ext_2;
   logic [31:0] rdata_ext, rdata_ext_2;

   prog_t prog;
   int plen;
   logic [15:0] lfsr_state;
   int errors, tests_passed, tests_failed;

   cpu dut0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .enable     (enable),
      .addr_ext   (addr_ext),
      .wen_ext    (wen_ext),
      .ren_ext    (ren_ext),
      .wdata_ext  (wdata_ext),
      .addr_ext_2 (addr_ext_2),
      .wen_ext_2  (wen_ext_2),
      .ren_ext_2  (ren_ext_2),
      .wdata_ext_2(wdata_ext_2),
      .rdata_ext  (rdata_ext),
      .rdata_ext_2(rdata_ext_2)
   );

   always #(PERIOD_NS / 2) clk = ~clk;

   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = (v << 1) | int'(lfsr_state[0]);
      end
      return v;
   endfunction

   task automatic emit(input logic [31:0] w);
      prog[plen] = w;
      plen++;
   endtask

   // registers keep their values across tests, so every program zeroes r1..r15
   task automatic start_program();
      foreach (prog[i]) prog[i] = '0;
      plen = 0;
      for (int i = 1; i < 16; i++) begin
         emit(itype_word(OP_ADDI, 5'(i), 5'd0, 16'd0));
      end
   endtask

   // store r1..r15 to words 1..15, then spin on a jump to itself
   task automatic finish_program();
      for (int i = 1; i < 16; i++) begin
         emit(itype_word(OP_SW, 5'(i), 5'd0, 16'(4 * i)));
      end
      emit(jump_word(26'(plen)));
   endtask

   // one strobe on a test port; read data is valid one cycle later
   task automatic port_access(input bit data_side, input bit write, input int addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
      @(negedge clk);
      if (data_side) begin
         addr_ext_2 = addr;
         wdata_ext_2 = wdata;
         wen_ext_2 = write;
         ren_ext_2 = !write;
      end else begin
         addr_ext = addr;
         wdata_ext = wdata;
         wen_ext = write;
         ren_ext = !write;
      end
      @(negedge clk);
      wen_ext = 1'b0;
      ren_ext = 1'b0;
      wen_ext_2 = 1'b0;
      ren_ext_2 = 1'b0;
      rdata = data_side ? rdata_ext_2 : rdata_ext;
   endtask

   task automatic run_test(input string name, input bit freeze);
      data_t expected;
      logic [31:0] got;
      int budget;
      int mismatches;
      mismatches = 0;
      budget = 2 * plen + 30;
      run_reference(prog, expected);
      @(negedge clk);
      arst_n = 1'b0;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      for (int i = 0; i < plen; i++) begin
         port_access(1'b0, 1'b1, i, prog[i], got);
      end
      for (int i = 0; i < CHECK_WORDS; i++) begin
         port_access(1'b1, 1'b1, i, '0, got);
      end
      enable = 1'b1;
      if (freeze) begin
         repeat (FREEZE_AFTER) @(negedge clk);
         enable = 1'b0;
         for (int i = 0; i < 3; i++) begin
            port_access(1'b0, 1'b0, i, '0, got);
            if (got !== prog[i]) begin
               $display("ERROR %s frozen read of instruction %0d expected %h actual %h",
                        name, i, prog[i], got);
               mismatches++;
            end
         end
         enable = 1'b1;
      end
      repeat (budget) @(negedge clk);
      enable = 1'b0;
      for (int i = 0; i < CHECK_WORDS; i++) begin
         port_access(1'b1, 1'b0, i, '0, got);
         if (got !== expected[i]) begin
            $display("ERROR %s word %0d expected %h actual %h", name, i, expected[i], got);
            mismatches++;
         end
      end
      errors += mismatches;
      if (mismatches == 0) begin
         tests_passed++;
         $display("test %s passed", name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d mismatches", name, mismatches);
      end
   endtask

   task automatic build_alu();
      start_program();
      emit(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd100));
      emit(itype_word(OP_ADDI, 5'd2, 5'd0, 16'(-7)));
      emit(itype_word(OP_ADDI, 5'd3, 5'd0, 16'h0F0F));
      emit(rtype_word(FN_ADD, 5'd4, 5'd1, 5'd2));
      emit(rtype_word(FN_SUB, 5'd5, 5'd1, 5'd2));
      emit(rtype_word(FN_AND, 5'd6, 5'd1, 5'd3));
      emit(rtype_word(FN_OR, 5'd7, 5'd2, 5'd3));
      emit(rtype_word(FN_SLT, 5'd8, 5'd2, 5'd1));
      emit(rtype_word(FN_SLT, 5'd9, 5'd1, 5'd2));
      emit(rtype_word(FN_SUB, 5'd10, 5'd2, 5'd1));
      emit(rtype_word(FN_SLT, 5'd11, 5'd10, 5'd2));
      emit(rtype_word(FN_SLT, 5'd12, 5'd2, 5'd10));
      emit(rtype_word(FN_AND, 5'd13, 5'd2, 5'd10));
      finish_program();
   endtask

   // producers at distance one and two on both operands
   task automatic build_forwarding();
      start_program();
      emit(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd5));
      emit(itype_word(OP_ADDI, 5'd2, 5'd1, 16'd3));
      emit(rtype_word(FN_ADD, 5'd3, 5'd2, 5'd1));
      emit(rtype_word(FN_ADD, 5'd4, 5'd1, 5'd3));
      emit(rtype_word(FN_SUB, 5'd5, 5'd4, 5'd4));
      emit(rtype_word(FN_OR, 5'd6, 5'd3, 5'd4));
      emit(rtype_word(FN_ADD, 5'd7, 5'd6, 5'd6));
      emit(rtype_word(FN_AND, 5'd8, 5'd7, 5'd6));
      emit(rtype_word(FN_SLT, 5'd9, 5'd8, 5'd7));
      emit(rtype_word(FN_ADD, 5'd10, 5'd7, 5'd8));
      emit(itype_word(OP_SW, 5'd10, 5'd0, 16'd80));
      finish_program();
   endtask

   task automatic build_loads();
      start_program();
      emit(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd1234));
      emit(itype_word(OP_SW, 5'd1, 5'd0, 16'd96));
      emit(itype_word(OP_LW, 5'd2, 5'd0, 16'd96));
      emit(rtype_word(FN_ADD, 5'd3, 5'd2, 5'd1));
      emit(itype_word(OP_SW, 5'd3, 5'd0, 16'd100));
      emit(itype_word(OP_LW, 5'd4, 5'd0, 16'd100));
      emit(itype_word(OP_LW, 5'd5, 5'd0, 16'd96));
      emit(rtype_word(FN_ADD, 5'd6, 5'd4, 5'd5));
      emit(itype_word(OP_ADDI, 5'd8, 5'd0, 16'd104));
      emit(itype_word(OP_SW, 5'd8, 5'd0, 16'd104));
      emit(itype_word(OP_LW, 5'd9, 5'd0, 16'd104));
      // loaded value used as the store base
      emit(itype_word(OP_SW, 5'd6, 5'd9, 16'd4));
      emit(itype_word(OP_LW, 5'd10, 5'd0, 16'd108));
      emit(rtype_word(FN_SUB, 5'd11, 5'd10, 5'd4));
      finish_program();
   endtask

   // word 16 holds a marker that only skipped instructions would clear
   task automatic build_control();
      start_program();
      emit(itype_word(OP_ADDI, 5'd1, 5'd0, 16'd85));
      emit(itype_word(OP_SW, 5'd1, 5'd0, 16'd64));
      emit(itype_word(OP_ADDI, 5'd2, 5'd0, 16'd7));
      emit(itype_word(OP_ADDI, 5'd3, 5'd0, 16'd3));
      emit(itype_word(OP_ADDI, 5'd4, 5'd3, 16'd4));
      emit(itype_word(OP_BEQ, 5'd4, 5'd2, 16'd2));
      emit(itype_word(OP_SW, 5'd0, 5'd0, 16'd64));
      emit(itype_word(OP_ADDI, 5'd5, 5'd0, 16'd99));
      emit(rtype_word(FN_SUB, 5'd6, 5'd2, 5'd3));
      emit(itype_word(OP_BEQ, 5'd6, 5'd3, 16'd1));
      emit(itype_word(OP_ADDI, 5'd7, 5'd0, 16'd11));
      emit(jump_word(26'(plen + 3)));
      emit(itype_word(OP_SW, 5'd0, 5'd0, 16'd64));
      emit(itype_word(OP_ADDI, 5'd8, 5'd0, 16'd66));
      emit(itype_word(OP_ADDI, 5'd9, 5'd0, 16'd12));
      emit(itype_word(OP_BEQ, 5'd0, 5'd0, 16'd1));
      emit(itype_word(OP_SW, 5'd0, 5'd0, 16'd64));
      finish_program();
   endtask

   task automatic build_random();
      int fn_table [5];
      int kind;
      logic [4:0] rd, rs, rt;
      fn_table = '{32, 34, 36, 37, 42};
      start_program();
      for (int i = 1; i < 16; i++) begin
         emit(itype_word(OP_ADDI, 5'(i), 5'd0, 16'(rand_bits(16))));
      end
      for (int i = 0; i < 40; i++) begin
         kind = rand_bits(3);
         rd = 5'(1 + rand_bits(4) % 15);
         rs = 5'(1 + rand_bits(4) % 15);
         rt = 5'(1 + rand_bits(4) % 15);
         if (kind < 5) begin
            emit(rtype_word(6'(fn_table[kind]), rd, rs, rt));
         end else begin
            emit(itype_word(OP_ADDI, rd, rs, 16'(rand_bits(16))));
         end
      end
      finish_program();
   endtask

   initial begin
      clk = 1'b0;
      arst_n = 1'b0;
      enable = 1'b0;
      addr_ext = '0;
      wen_ext = 1'b0;
      ren_ext = 1'b0;
      wdata_ext = '0;
      addr_ext_2 = '0;
      wen_ext_2 = 1'b0;
      ren_ext_2 = 1'b0;
      wdata_ext_2 = '0;
      lfsr_state = 16'd87;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      build_alu();
      run_test("alu_ops", 1'b0);
      build_forwarding();
      run_test("forwarding", 1'b0);
      build_loads();
      run_test("load_use", 1'b0);
      build_control();
      run_test("control_flow", 1'b0);
      build_forwarding();
      run_test("enable_freeze", 1'b1);
      build_random();
      run_test("random_program", 1'b0);
      $display("%0d tests passed, %0d tests failed, %0d mismatches",
               tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* cpu.f */
+incdir+include
logic/cpu_pkg.sv
logic/dual_port_sram.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu.sv
sim/cpu_tb_model.sv
sim/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the CPU testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing -f cpu.f --top-module cpu_tb -o cpu_tb_sim &&
./obj_dir/cpu_tb_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }
